/* design/addr_cfg.svh */
////////////////////
// Address unit configuration.
// Reset values of the sixteen-bit pointers.
////////////////////
`ifndef ADDR_CFG_SVH
`define ADDR_CFG_SVH

// Program counter starts at the bottom of memory.
`define ADDR_PC_RESET 16'h0000

// Stack grows down from the top.
`define ADDR_SP_RESET 16'hFFFF

`endif

/* design/addrPkg.sv */
////////////////////
// Address path types shared by the design and the testbench.
////////////////////
`default_nettype none

package addrPkg;

    // Address sources. The value is also the select line index.
    typedef enum logic [3:0] {
        PC      = 4'd0,
        SP      = 4'd1,
        BC      = 4'd2,
        DE      = 4'd3,
        HL      = 4'd4,
        IR      = 4'd5,
        DTEXDT  = 4'd6,
        OPOPOLD = 4'd7,
        ALU     = 4'd8,
        AOP     = 4'd9
    } addrSrcE;

    typedef enum logic [1:0] {
        LOAD    = 2'd0,
        EMIT    = 2'd1,
        EMITINC = 2'd2,
        EMITDEC = 2'd3
    } cmdOpE;

    typedef struct packed {
        cmdOpE       op;
        addrSrcE     src;
        logic [15:0] data;
    } addrCmdT;

    // Everything here is inverted, as on the internal buses.
    typedef struct packed {
        logic [7:0]  aN;
        logic [7:0]  bN;
        logic [7:0]  cN;
        logic [7:0]  dN;
        logic [7:0]  eN;
        logic [7:0]  hN;
        logic [7:0]  lN;
        logic [7:0]  iN;
        logic [7:0]  rN;
        logic [7:0]  dtN;
        logic [7:0]  dtexN;
        logic [7:0]  opN;
        logic [7:0]  opOldN;
        logic [15:0] pcN;
        logic [15:0] spN;
        logic [15:0] aluN;
    } regViewT;

    // Value is in true polarity.
    typedef struct packed {
        logic        en;
        addrSrcE     pair;
        logic [15:0] value;
    } regWriteT;

    // Active-low one-hot selects, bit order follows addrSrcE.
    typedef logic [9:0] selNT;

endpackage

`default_nettype wire

/* design/addressRegisterFile.sv */
////////////////////
// Address register file: all address-source registers, stored inverted,
// with one pair-wide write port.
////////////////////
`default_nettype none
`timescale 1ns/1ps
`include "addr_cfg.svh"

module addressRegisterFile (
    input  logic              clk,
    input  logic              rstN,
    input  addrPkg::regWriteT regWrite,
    input  logic [15:0]       alu,
    output addrPkg::regViewT  regView
);
    import addrPkg::*;

    logic [7:0]  aN;
    logic [7:0]  bN;
    logic [7:0]  cN;
    logic [7:0]  dN;
    logic [7:0]  eN;
    logic [7:0]  hN;
    logic [7:0]  lN;
    logic [7:0]  iN;
    logic [7:0]  rN;
    logic [7:0]  dtN;
    logic [7:0]  dtexN;
    logic [7:0]  opN;
    logic [7:0]  opOldN;
    logic [15:0] pcN;
    logic [15:0] spN;

    // Incoming bytes, already flipped to storage polarity.
    logic [7:0] hiN;
    logic [7:0] loN;

    assign hiN = ~regWrite.value[15:8];
    assign loN = ~regWrite.value[7:0];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aN     <= 8'hFF;
            bN     <= 8'hFF;
            cN     <= 8'hFF;
            dN     <= 8'hFF;
            eN     <= 8'hFF;
            hN     <= 8'hFF;
            lN     <= 8'hFF;
            iN     <= 8'hFF;
            rN     <= 8'hFF;
            dtN    <= 8'hFF;
            dtexN  <= 8'hFF;
            opN    <= 8'hFF;
            opOldN <= 8'hFF;
            pcN    <= ~`ADDR_PC_RESET;
            spN    <= ~`ADDR_SP_RESET;
        end else if (regWrite.en) begin
            // First register of a pair takes the high byte.
            case (regWrite.pair)
                PC: pcN <= {hiN, loN};
                SP: spN <= {hiN, loN};
                BC: begin
                    bN <= hiN;
                    cN <= loN;
                end
                DE: begin
                    dN <= hiN;
                    eN <= loN;
                end
                HL: begin
                    hN <= hiN;
                    lN <= loN;
                end
                IR: begin
                    iN <= hiN;
                    rN <= loN;
                end
                DTEXDT: begin
                    dtexN <= hiN;
                    dtN   <= loN;
                end
                OPOPOLD: begin
                    opN    <= hiN;
                    opOldN <= loN;
                end
                AOP: begin
                    aN  <= hiN;
                    opN <= loN;
                end
                default: ;  // ALU has no storage.
            endcase
        end
    end

    always_comb begin
        regView.aN     = aN;
        regView.bN     = bN;
        regView.cN     = cN;
        regView.dN     = dN;
        regView.eN     = eN;
        regView.hN     = hN;
        regView.lN     = lN;
        regView.iN     = iN;
        regView.rN     = rN;
        regView.dtN    = dtN;
        regView.dtexN  = dtexN;
        regView.opN    = opN;
        regView.opOldN = opOldN;
        regView.pcN    = pcN;
        regView.spN    = spN;
        regView.aluN   = ~alu;
    end

endmodule

`default_nettype wire

/* design/addressMux.sv */
////////////////////
// Address mux: picks one of ten inverted sixteen-bit sources
// with active-low selects.
////////////////////
`default_nettype none
`timescale 1ns/1ps

module addressMux (
    input  addrPkg::regViewT regView,
    input  addrPkg::selNT    selN,
    output logic [15:0]      selectedAdN
);
    import addrPkg::*;

    // Each byte passes only when its select is low.
    logic [7:0] hiPc;
    logic [7:0] hiSp;
    logic [7:0] hiB;
    logic [7:0] hiD;
    logic [7:0] hiH;
    logic [7:0] hiI;
    logic [7:0] hiDtex;
    logic [7:0] hiOp;
    logic [7:0] hiAlu;
    logic [7:0] hiA;

    logic [7:0] loPc;
    logic [7:0] loSp;
    logic [7:0] loC;
    logic [7:0] loE;
    logic [7:0] loL;
    logic [7:0] loR;
    logic [7:0] loDt;
    logic [7:0] loOpOld;
    logic [7:0] loAlu;
    logic [7:0] loOp;

    assign hiPc   = ~(regView.pcN[15:8]  | {8{selN[PC]}});
    assign hiSp   = ~(regView.spN[15:8]  | {8{selN[SP]}});
    assign hiB    = ~(regView.bN         | {8{selN[BC]}});
    assign hiD    = ~(regView.dN         | {8{selN[DE]}});
    assign hiH    = ~(regView.hN         | {8{selN[HL]}});
    assign hiI    = ~(regView.iN         | {8{selN[IR]}});
    assign hiDtex = ~(regView.dtexN      | {8{selN[DTEXDT]}});
    assign hiOp   = ~(regView.opN        | {8{selN[OPOPOLD]}});
    assign hiAlu  = ~(regView.aluN[15:8] | {8{selN[ALU]}});
    assign hiA    = ~(regView.aN         | {8{selN[AOP]}});

    assign loPc    = ~(regView.pcN[7:0]  | {8{selN[PC]}});
    assign loSp    = ~(regView.spN[7:0]  | {8{selN[SP]}});
    assign loC     = ~(regView.cN        | {8{selN[BC]}});
    assign loE     = ~(regView.eN        | {8{selN[DE]}});
    assign loL     = ~(regView.lN        | {8{selN[HL]}});
    assign loR     = ~(regView.rN        | {8{selN[IR]}});
    assign loDt    = ~(regView.dtN       | {8{selN[DTEXDT]}});
    assign loOpOld = ~(regView.opOldN    | {8{selN[OPOPOLD]}});
    assign loAlu   = ~(regView.aluN[7:0] | {8{selN[ALU]}});
    // OP sits low when paired with A.
    assign loOp    = ~(regView.opN       | {8{selN[AOP]}});

    // Gated bytes are true values, so the OR is inverted back.
    assign selectedAdN[15:8] = ~(hiPc | hiSp | hiB | hiD | hiH |
                                 hiI | hiDtex | hiOp | hiAlu | hiA);
    assign selectedAdN[7:0]  = ~(loPc | loSp | loC | loE | loL |
                                 loR | loDt | loOpOld | loAlu | loOp);

endmodule

`default_nettype wire

/* design/addressSequencer.sv */
////////////////////
// Address sequencer: command handshake, pair select, pair update
// and the registered outgoing address.
////////////////////
`default_nettype none
`timescale 1ns/1ps

module addressSequencer (
    input  logic              clk,
    input  logic              rstN,
    input  logic              cmdValid,
    input  addrPkg::addrCmdT  cmd,
    output logic              cmdReady,
    output addrPkg::selNT     selN,
    input  logic [15:0]       selectedAdN,
    output addrPkg::regWriteT regWrite,
    output logic              addrValid,
    output logic [15:0]       addressN,
    input  logic              addrReady
);
    import addrPkg::*;

    logic        accept;
    logic        isEmit;
    logic        writeBackOk;
    logic [15:0] pairValue;

    // Output slot frees up when empty or being drained.
    assign cmdReady = !addrValid || addrReady;
    assign accept   = cmdValid && cmdReady;
    assign isEmit   = (cmd.op != LOAD);

    // One select low, taken straight from the source code.
    assign selN = ~(10'b1 << cmd.src);

    assign pairValue = ~selectedAdN;

    // ALU, OP/OPold and A/OP are never stepped.
    assign writeBackOk = (cmd.src != ALU) && (cmd.src != OPOPOLD) && (cmd.src != AOP);

    always_comb begin
        regWrite.pair  = cmd.src;
        regWrite.en    = 1'b0;
        regWrite.value = cmd.data;
        case (cmd.op)
            LOAD: begin
                regWrite.en = accept && (cmd.src != ALU);
            end
            EMITINC: begin
                regWrite.en    = accept && writeBackOk;
                regWrite.value = pairValue + 16'd1;
            end
            EMITDEC: begin
                regWrite.en    = accept && writeBackOk;
                regWrite.value = pairValue - 16'd1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            addrValid <= 1'b0;
        end else if (accept && isEmit) begin
            addrValid <= 1'b1;
        end else if (addrReady) begin
            addrValid <= 1'b0;
        end
    end

    // Captures the value before any write-back on the same edge.
    always_ff @(posedge clk) begin
        if (accept && isEmit) begin
            addressN <= selectedAdN;
        end
    end

endmodule

`default_nettype wire

/* design/addressUnit.sv */
////////////////////
// Address unit top: register file, source mux and sequencer.
////////////////////
`default_nettype none
`timescale 1ns/1ps

module addressUnit (
    input  logic             clk,
    input  logic             rstN,
    input  logic             cmdValid,
    input  addrPkg::addrCmdT cmd,
    output logic             cmdReady,
    input  logic [15:0]      alu,
    output logic             addrValid,
    output logic [15:0]      address,
    input  logic             addrReady
);
    import addrPkg::*;

    regWriteT    regWrite;
    regViewT     regView;
    selNT        selN;
    logic [15:0] selectedAdN;
    logic [15:0] addressN;

    addressRegisterFile uRegFile (
        .clk      (clk),
        .rstN     (rstN),
        .regWrite (regWrite),
        .alu      (alu),
        .regView  (regView)
    );

    addressMux uMux (
        .regView     (regView),
        .selN        (selN),
        .selectedAdN (selectedAdN)
    );

    addressSequencer uSeq (
        .clk         (clk),
        .rstN        (rstN),
        .cmdValid    (cmdValid),
        .cmd         (cmd),
        .cmdReady    (cmdReady),
        .selN        (selN),
        .selectedAdN (selectedAdN),
        .regWrite    (regWrite),
        .addrValid   (addrValid),
        .addressN    (addressN),
        .addrReady   (addrReady)
    );

    // Memory side sees the address true.
    assign address = ~addressN;

endmodule

`default_nettype wire

/* tb/addressUnit_properties.sv */
////////////////////
// Handshake and select assertions for the address unit.
////////////////////
`default_nettype none
`timescale 1ns/1ps

module addressUnit_properties (
    input wire logic          clk,
    input wire logic          rstN,
    input wire logic          cmdValid,
    input wire logic          cmdReady,
    input wire logic          addrValid,
    input wire logic [15:0]   address,
    input wire logic          addrReady,
    input wire addrPkg::selNT selN
);

    // Quiet through reset and the first cycle after it.
    validLowInReset: assert property (
        @(posedge clk) (!rstN || $rose(rstN)) |=> !addrValid
    ) else $error("addrValid high during or right after reset");

    // Stalled address holds.
    holdUnderStall: assert property (
        @(posedge clk) disable iff (!rstN)
        (addrValid && !addrReady) |=> (addrValid && $stable(address))
    ) else $error("address changed under back-pressure");

    oneSelectLow: assert property (
        @(posedge clk) disable iff (!rstN)
        (cmdValid && cmdReady) |-> $onehot(~selN)
    ) else $error("select lines not one-hot low on accept");

endmodule

bind addressUnit addressUnit_properties props (
    .clk       (clk),
    .rstN      (rstN),
    .cmdValid  (cmdValid),
    .cmdReady  (cmdReady),
    .addrValid (addrValid),
    .address   (address),
    .addrReady (addrReady),
    .selN      (selN)
);

`default_nettype wire

/* tb/addressUnitTb.sv */
////////////////////
// Testbench for the address unit: command table, register model,
// random memory back-pressure and in-order address checks.
////////////////////
`default_nettype none
`timescale 1ns/1ps
`include "addr_cfg.svh"

module addressUnitTb;
    import addrPkg::*;

    typedef struct packed {
        cmdOpE       op;
        addrSrcE     src;
        logic [15:0] data;
        logic [15:0] expAddr;
        logic        hasExp;
    } stepT;

    localparam logic [15:0] AluValue = 16'h5AC3;

    logic        clk;
    logic        rstN;
    logic        cmdValid;
    addrCmdT     cmd;
    logic        cmdReady;
    logic [15:0] alu;
    logic        addrValid;
    logic [15:0] address;
    logic        addrReady;

    stepT        steps[$];
    logic [15:0] expQ[$];
    longint      timeoutNs;
    bit          tableReady;

    // Reference register model, true polarity.
    logic [7:0]  mA, mB, mC, mD, mE, mH, mL, mI, mR;
    logic [7:0]  mDt, mDtex, mOp, mOpOld;
    logic [15:0] mPc, mSp;

    addressUnit DUT (
        .clk       (clk),
        .rstN      (rstN),
        .cmdValid  (cmdValid),
        .cmd       (cmd),
        .cmdReady  (cmdReady),
        .alu       (alu),
        .addrValid (addrValid),
        .address   (address),
        .addrReady (addrReady)
    );

    always #10 clk = ~clk;

    task automatic checkValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is %h, expected %h", name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic addStep(input cmdOpE op, input addrSrcE src, input logic [15:0] data,
                           input logic [15:0] expAddr, input logic hasExp);
        stepT s;
        s.op      = op;
        s.src     = src;
        s.data    = data;
        s.expAddr = expAddr;
        s.hasExp  = hasExp;
        steps.push_back(s);
    endtask

    function automatic logic [15:0] readPair(input addrSrcE src);
        case (src)
            PC:      return mPc;
            SP:      return mSp;
            BC:      return {mB, mC};
            DE:      return {mD, mE};
            HL:      return {mH, mL};
            IR:      return {mI, mR};
            DTEXDT:  return {mDtex, mDt};
            OPOPOLD: return {mOp, mOpOld};
            ALU:     return alu;
            default: return {mA, mOp};
        endcase
    endfunction

    task automatic writePair(input addrSrcE src, input logic [15:0] v);
        case (src)
            PC:      mPc = v;
            SP:      mSp = v;
            BC:      {mB, mC} = v;
            DE:      {mD, mE} = v;
            HL:      {mH, mL} = v;
            IR:      {mI, mR} = v;
            DTEXDT:  {mDtex, mDt} = v;
            OPOPOLD: {mOp, mOpOld} = v;
            AOP:     {mA, mOp} = v;
            default: ;
        endcase
    endtask

    // Applies one accepted command to the model and queues its address.
    task automatic applyModel(input stepT s);
        logic [15:0] cur;
        logic        stepOk;
        cur    = readPair(s.src);
        stepOk = (s.src != ALU) && (s.src != OPOPOLD) && (s.src != AOP);
        if (s.op == LOAD) begin
            writePair(s.src, s.data);
        end else begin
            if (s.hasExp) begin
                checkValue("table expected address", cur, s.expAddr);
            end
            expQ.push_back(cur);
            if (s.op == EMITINC && stepOk) writePair(s.src, cur + 16'd1);
            if (s.op == EMITDEC && stepOk) writePair(s.src, cur - 16'd1);
        end
    endtask

    task automatic buildTable();
        addStep(EMIT,    PC,      16'h0000, 16'h0000, 1'b1);
        addStep(EMIT,    SP,      16'h0000, 16'hFFFF, 1'b1);
        addStep(LOAD,    BC,      16'h1234, 16'h0000, 1'b0);
        addStep(EMIT,    BC,      16'h0000, 16'h1234, 1'b1);
        addStep(LOAD,    DE,      16'h5678, 16'h0000, 1'b0);
        addStep(EMIT,    DE,      16'h0000, 16'h5678, 1'b1);
        addStep(LOAD,    HL,      16'h9ABC, 16'h0000, 1'b0);
        addStep(EMIT,    HL,      16'h0000, 16'h9ABC, 1'b1);
        addStep(LOAD,    IR,      16'hDEF0, 16'h0000, 1'b0);
        addStep(EMIT,    IR,      16'h0000, 16'hDEF0, 1'b1);
        addStep(LOAD,    DTEXDT,  16'h0F1E, 16'h0000, 1'b0);
        addStep(EMIT,    DTEXDT,  16'h0000, 16'h0F1E, 1'b1);
        addStep(LOAD,    OPOPOLD, 16'h3344, 16'h0000, 1'b0);
        addStep(EMIT,    OPOPOLD, 16'h0000, 16'h3344, 1'b1);
        addStep(LOAD,    AOP,     16'h7788, 16'h0000, 1'b0);
        addStep(EMIT,    AOP,     16'h0000, 16'h7788, 1'b1);
        // OP was overwritten through A/OP and now shows high.
        addStep(EMIT,    OPOPOLD, 16'h0000, 16'h8844, 1'b1);
        addStep(EMITINC, PC,      16'h0000, 16'h0000, 1'b1);
        addStep(EMIT,    PC,      16'h0000, 16'h0001, 1'b1);
        addStep(EMITDEC, PC,      16'h0000, 16'h0001, 1'b1);
        addStep(EMITDEC, PC,      16'h0000, 16'h0000, 1'b1);
        addStep(EMIT,    PC,      16'h0000, 16'hFFFF, 1'b1);
        addStep(EMITINC, SP,      16'h0000, 16'hFFFF, 1'b1);
        addStep(EMIT,    SP,      16'h0000, 16'h0000, 1'b1);
        addStep(LOAD,    BC,      16'hFFFF, 16'h0000, 1'b0);
        addStep(EMITINC, BC,      16'h0000, 16'hFFFF, 1'b1);
        addStep(EMIT,    BC,      16'h0000, 16'h0000, 1'b1);
        addStep(EMITDEC, BC,      16'h0000, 16'h0000, 1'b1);
        addStep(EMIT,    BC,      16'h0000, 16'hFFFF, 1'b1);
        addStep(EMITINC, ALU,     16'h0000, AluValue, 1'b1);
        addStep(EMITDEC, AOP,     16'h0000, 16'h7788, 1'b1);
        addStep(EMIT,    AOP,     16'h0000, 16'h7788, 1'b1);
        addStep(EMITINC, OPOPOLD, 16'h0000, 16'h8844, 1'b1);
        addStep(EMIT,    OPOPOLD, 16'h0000, 16'h8844, 1'b1);
        addStep(LOAD,    ALU,     16'h1111, 16'h0000, 1'b0);
        addStep(EMIT,    ALU,     16'h0000, AluValue, 1'b1);
        // Repeated stepping, checked only through the model.
        addStep(EMITINC, HL,      16'h0000, 16'h0000, 1'b0);
        addStep(EMITINC, HL,      16'h0000, 16'h0000, 1'b0);
        addStep(EMITDEC, DE,      16'h0000, 16'h0000, 1'b0);
        addStep(EMITDEC, DE,      16'h0000, 16'h0000, 1'b0);
        addStep(EMIT,    HL,      16'h0000, 16'h9ABE, 1'b1);
        addStep(EMIT,    DE,      16'h0000, 16'h5676, 1'b1);
    endtask

    // Memory side stalls at random.
    always @(posedge clk) begin
        #2;
        if (rstN) addrReady <= ($urandom() & 32'd1) != 0;
    end

    // Handshake is sampled mid-cycle where all inputs are settled.
    always @(negedge clk) begin
        if (rstN) begin
            // At most one address is in flight, so a queued address means valid.
            checkValue("addrValid", addrValid, expQ.size() != 0);
            checkValue("cmdReady", cmdReady, (expQ.size() == 0) || addrReady);
            if (addrValid && addrReady) begin
                checkValue("address", address, expQ.pop_front());
            end
        end
    end

    initial begin
        wait (tableReady);
        #(timeoutNs);
        $display("Error: the run hung, addresses stopped arriving");
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        bit  ready;
        clk       = 1'b0;
        rstN      = 1'b0;
        cmdValid  = 1'b0;
        cmd       = '0;
        alu       = AluValue;
        addrReady = 1'b0;
        void'($urandom(32'h824e_169d));
        {mA, mB, mC, mD, mE, mH, mL, mI, mR} = '0;
        {mDt, mDtex, mOp, mOpOld} = '0;
        mPc = `ADDR_PC_RESET;
        mSp = `ADDR_SP_RESET;
        buildTable();
        timeoutNs  = (longint'(steps.size()) * 40 + 20) * 20;
        tableReady = 1'b1;

        repeat (10) @(posedge clk);
        #2;
        rstN = 1'b1;

        foreach (steps[i]) begin
            @(posedge clk);
            #2;
            cmdValid = 1'b1;
            cmd.op   = steps[i].op;
            cmd.src  = steps[i].src;
            cmd.data = steps[i].data;
            do begin
                @(negedge clk);
                ready = cmdReady;
                @(posedge clk);
            end while (!ready);
            applyModel(steps[i]);
            #2;
            cmdValid = 1'b0;
        end

        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        // Idle cycles let a duplicated address show up.
        repeat (5) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+design
design/addrPkg.sv
design/addressRegisterFile.sv
design/addressMux.sv
design/addressSequencer.sv
design/addressUnit.sv
tb/addressUnit_properties.sv
tb/addressUnitTb.sv

/* Makefile */
# Verilator build for the address unit testbench.

VERILATOR ?= verilator
TOP       ?= addressUnitTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert
JOBS      ?= 4

BIN := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard design/*.sv design/*.svh tb/*.sv)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJDIR) -f $(FILELIST)

# Exit status follows the simulation result.
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
